/* buck_modulation_top.f */
+incdir+common
common/buck_pkg.sv
common/pwm_write_bus.sv
source/buck_pre_modulation_processor.sv
pwm/pwm_register_bank.sv
pwm/pwm_carrier.sv
pwm/pwm_gate_driver.sv
source/buck_modulation_top.sv
sim/tb_clock_gen.sv
sim/buck_tb.sv

/* common/buck_params.svh */
/*
 * Buck modulation sizing macros: phase count, counter width,
 * configured deadtime and register group stride
 */
`ifndef BUCK_PARAMS_SVH
`define BUCK_PARAMS_SVH

// Number of converter phases, one PWM channel each
`define BUCK_N_PHASES 4

// Width of period, duty, shift and deadtime values
`define BUCK_CNT_W 16

// Deadtime in clocks written at configuration
`define BUCK_DEADTIME 5

// Address distance between phase register groups
`define BUCK_CHAIN_STRIDE 16'h100

`endif

/* common/buck_pkg.sv */
/*
 * Shared types for the buck modulator: write destination union,
 * register offsets, global control bits and processor states
 */
package buck_pkg;

    // Offsets inside one phase register group
    typedef enum logic [7:0] {
        reg_duty            = 8'h04, // Compare high
        reg_deadtime        = 8'h08,
        reg_period          = 8'h0c,
        reg_counter_stop    = 8'h10,
        reg_phase_shift     = 8'h14,
        reg_output_enable   = 8'h18,
        reg_deadtime_enable = 8'h1c,
        reg_chain_control   = 8'h20
    } pwm_reg_e;

    typedef struct packed {
        logic [23:0] chain;  // 0 is global, k+1 is phase k
        pwm_reg_e    offset;
    } pwm_dest_t;

    // Same destination word seen as a flat address or as chain and offset
    typedef union packed {
        logic [31:0] raw;
        pwm_dest_t   fields;
    } pwm_addr_u;

    // Global control register bits
    localparam int gc_run = 0;
    localparam int gc_out_en = 1;
    localparam logic [31:0] gc_idle_word = 32'h0;
    localparam logic [31:0] gc_on_word = 32'h3;

    typedef enum logic [2:0] {
        idle,
        wait_period,
        configure_chain,
        configure_shifts,
        write_strobe,
        wait_start,
        update_duty
    } proc_state_e;

endpackage

/* common/pwm_write_bus.sv */
/*
 * Register write bus between the modulation processor and the PWM bank
 */
interface pwm_write_bus import buck_pkg::*; ();

    pwm_addr_u   dest;
    logic [31:0] data;
    logic        valid; // One clock pulse per write
    logic        ready; // Low for one clock after each write

    modport processor (
        output dest,
        output data,
        output valid,
        input  ready
    );

    modport bank (
        input  dest,
        input  data,
        input  valid,
        output ready
    );

endinterface

/* pwm/pwm_carrier.sv */
/*
 * PWM carrier with one up counter per phase, preloaded with its shift
 */
`include "buck_params.svh"

module pwm_carrier (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic [`BUCK_CNT_W-1:0] period,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] phase_shift,
    output logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] count
);

    logic [`BUCK_CNT_W-1:0] last_count;

    assign last_count = period - 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else begin
            for (int i = 0; i < `BUCK_N_PHASES; i++) begin
                if (!run) begin
                    count[i] <= phase_shift[i]; // Offsets kept for run rise
                end else if (count[i] >= last_count) begin
                    count[i] <= '0;
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* pwm/pwm_gate_driver.sv */
/*
 * Gate driver. Compares carrier count with duty and produces
 * complementary high and low gates with deadtime on both edges
 */
`include "buck_params.svh"

module pwm_gate_driver (
    input  logic clock,
    input  logic reset,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] count,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] duty,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] deadtime,
    input  logic [`BUCK_N_PHASES-1:0] output_enable,
    input  logic [`BUCK_N_PHASES-1:0] deadtime_enable,
    output logic [`BUCK_N_PHASES-1:0] gate_high,
    output logic [`BUCK_N_PHASES-1:0] gate_low
);

    logic [`BUCK_N_PHASES-1:0] raw;
    logic [`BUCK_N_PHASES-1:0] raw_q;
    logic [`BUCK_N_PHASES-1:0] settled;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] run_len;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] len_next;

    // Length of the current stretch of equal compare values
    always_comb begin
        for (int i = 0; i < `BUCK_N_PHASES; i++) begin
            raw[i] = count[i] < duty[i];
            if (raw[i] != raw_q[i]) begin
                len_next[i] = `BUCK_CNT_W'(1);
            end else if (run_len[i] == '1) begin
                len_next[i] = run_len[i]; // Saturate
            end else begin
                len_next[i] = run_len[i] + 1'b1;
            end
            settled[i] = !deadtime_enable[i] || len_next[i] > deadtime[i];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            raw_q <= '0;
            run_len <= '0;
            gate_high <= '0;
            gate_low <= '0;
        end else begin
            raw_q <= raw;
            run_len <= len_next;
            gate_high <= output_enable & raw & settled;
            gate_low <= output_enable & ~raw & settled;
        end
    end

endmodule

/* pwm/pwm_register_bank.sv */
/*
 * PWM register bank. Decodes bus writes into the global control
 * word and the per-phase duty, shift, deadtime and enable registers
 */
`include "buck_params.svh"

module pwm_register_bank import buck_pkg::*; (
    input  logic clock,
    input  logic reset,
    pwm_write_bus.bank bus,
    output logic run,
    output logic [`BUCK_CNT_W-1:0] period,
    output logic [`BUCK_N_PHASES-1:0] output_enable,
    output logic [`BUCK_N_PHASES-1:0] deadtime_enable,
    output logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] duty,
    output logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] phase_shift,
    output logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] deadtime
);

    logic run_q;
    logic out_en_q;
    logic [`BUCK_N_PHASES-1:0] oe_q;

    assign run = run_q;
    assign output_enable = oe_q & {`BUCK_N_PHASES{out_en_q}}; // Global gate on enables

    always_ff @(posedge clock) begin
        if (!reset) begin
            bus.ready <= 1'b1;
            run_q <= 1'b0;
            out_en_q <= 1'b0;
            oe_q <= '0;
            deadtime_enable <= '0;
            period <= '0;
            duty <= '0;
            phase_shift <= '0;
            deadtime <= '0;
        end else begin
            bus.ready <= !bus.valid; // One clock drop per write
            if (bus.valid) begin
                if (bus.dest.fields.chain == 24'd0 && bus.dest.fields.offset == 8'h00) begin
                    run_q <= bus.data[gc_run];
                    out_en_q <= bus.data[gc_out_en];
                end
                for (int i = 0; i < `BUCK_N_PHASES; i++) begin
                    if (bus.dest.fields.chain == 24'(i + 1)) begin
                        case (bus.dest.fields.offset)
                            reg_duty:            duty[i] <= bus.data[`BUCK_CNT_W-1:0];
                            reg_phase_shift:     phase_shift[i] <= bus.data[`BUCK_CNT_W-1:0];
                            reg_deadtime:        deadtime[i] <= bus.data[`BUCK_CNT_W-1:0];
                            reg_output_enable:   oe_q[i] <= bus.data[0];
                            reg_deadtime_enable: deadtime_enable[i] <= bus.data[0];
                            // Shared period, counter stop carries the same wrap value
                            reg_period, reg_counter_stop: period <= bus.data[`BUCK_CNT_W-1:0];
                            default: ; // Chain control and holes
                        endcase
                    end
                end
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the buck modulation testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module buck_tb -f buck_modulation_top.f -o buck_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/buck_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* sim/buck_tb.sv */
/*
 * Testbench for the buck modulation top. Configures, starts, updates
 * duty and stops the modulator while assertions watch the gates
 */
`include "buck_params.svh"

module buck_tb import buck_pkg::*; ();

    localparam int n_ph = `BUCK_N_PHASES;
    localparam int dt = `BUCK_DEADTIME;
    localparam int period_clocks = 100;
    localparam int c_reset_off = 0;
    localparam int c_done = 1;
    localparam int c_status_on = 2;
    localparam int c_status_off = 3;
    localparam int c_gates_off = 4;
    localparam int c_measured = 5;

    logic clock;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic update;
    logic [`BUCK_CNT_W-1:0] period_in;
    logic [`BUCK_CNT_W-1:0] duty_in;
    logic [n_ph-1:0][`BUCK_CNT_W-1:0] phase_shift_in;
    logic done;
    logic modulator_status;
    logic [n_ph-1:0] gate_high;
    logic [n_ph-1:0] gate_low;

    logic configured;
    logic started;
    logic stopped;
    logic armed; // Pulse measurement enabled
    logic [31:0] seed = 32'hc2ff5228;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int done_count = 0;
    int cycle = 0;
    int shift [n_ph];
    logic [n_ph-1:0] high_q;
    logic [n_ph-1:0] pulse_valid;
    logic [n_ph-1:0] rise_seen;
    logic [n_ph-1:0] meas_ok;
    int hi_len [n_ph];
    int meas_len [n_ph];
    int rise_cycle [n_ph];
    int since_fall [n_ph]; // Clocks since gate_high fell, 0 when idle

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    buck_modulation_top dut (
        .clock (clock), .reset (reset),
        .configure (configure), .start (start), .stop (stop), .update (update),
        .period_in (period_in), .duty_in (duty_in), .phase_shift_in (phase_shift_in),
        .done (done), .modulator_status (modulator_status),
        .gate_high (gate_high), .gate_low (gate_low)
    );

    task automatic report_fail(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Uniform pick in lo .. hi-1
    task automatic draw(input int lo, input int hi, output int v);
        seed = lcg_next(seed);
        v = lo + (int'(seed[31:16]) % (hi - lo));
    endtask

    function automatic logic cond_met(input int kind);
        case (kind)
            c_reset_off:  return reset;
            c_done:       return done;
            c_status_on:  return modulator_status;
            c_status_off: return !modulator_status;
            c_gates_off:  return gate_high == '0 && gate_low == '0;
            c_measured:   return &meas_ok;
            default:      return 1'b0;
        endcase
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s at time %0t", what, $time);
        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed + 1, errors);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic wait_until(input int kind, input int limit, input string what);
        int n;
        n = 0;
        while (!cond_met(kind) && n < limit) begin
            @(posedge clock);
            n++;
        end
        if (!cond_met(kind)) abort_on_timeout(what);
    endtask

    task automatic wait_state(input proc_state_e s, input int limit, input string what);
        int n;
        n = 0;
        while (dut.processor.state != s && n < limit) begin
            @(posedge clock);
            n++;
        end
        if (dut.processor.state != s) abort_on_timeout(what);
    endtask

    // One clock strobe: 0 configure, 1 start, 2 stop, 3 update
    task automatic pulse_strobe(input int which);
        @(posedge clock);
        case (which)
            0: configure <= 1'b1;
            1: start <= 1'b1;
            2: stop <= 1'b1;
            default: update <= 1'b1;
        endcase
        @(posedge clock);
        configure <= 1'b0;
        start <= 1'b0;
        stop <= 1'b0;
        update <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    // Skip one period so every duty write has settled, then take full pulses
    task automatic measure_duty(input int duty);
        armed <= 1'b0;
        repeat (period_clocks) @(posedge clock);
        armed <= 1'b1;
        wait_until(c_measured, 4 * period_clocks, "full gate pulses on every phase");
        for (int k = 0; k < n_ph; k++) begin
            assert (meas_len[k] == duty - dt)
                else report_fail($sformatf("phase %0d gate_high for %0d clocks, expected %0d",
                                           k, meas_len[k], duty - dt));
        end
    endtask

    assert property (@(posedge clock) disable iff (!reset) done |=> !done)
        else report_fail("done high for more than one clock");

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (reset) begin
            if (done) done_count <= done_count + 1;
            assert ((gate_high & gate_low) == '0)
                else report_fail("gate_high and gate_low on together");
            if (!configured) begin
                assert (!done) else report_fail("done before configuration");
            end
            if (!started) begin
                assert (!modulator_status && gate_high == '0 && gate_low == '0)
                    else report_fail("status or gates active before start");
            end
            if (stopped) begin
                assert (!modulator_status && gate_high == '0 && gate_low == '0)
                    else report_fail("status or gates active after stop");
            end
        end
    end

    // Per phase high time and first rise after arming
    always @(posedge clock) begin
        for (int k = 0; k < n_ph; k++) begin
            high_q[k] <= gate_high[k];
            if (!armed) begin
                pulse_valid[k] <= 1'b0;
                rise_seen[k] <= 1'b0;
                meas_ok[k] <= 1'b0;
            end else if (gate_high[k] && !high_q[k]) begin
                hi_len[k] <= 1;
                pulse_valid[k] <= 1'b1;
                if (!rise_seen[k]) begin
                    rise_cycle[k] <= cycle;
                    rise_seen[k] <= 1'b1;
                end
            end else if (gate_high[k]) begin
                hi_len[k] <= hi_len[k] + 1;
            end else if (high_q[k] && pulse_valid[k]) begin
                meas_len[k] <= hi_len[k];
                meas_ok[k] <= 1'b1;
            end
        end
    end

    // gate_low stays off for deadtime clocks after gate_high falls, then rises
    always @(posedge clock) begin
        for (int k = 0; k < n_ph; k++) begin
            if (!armed) begin
                since_fall[k] <= 0;
            end else if (high_q[k] && !gate_high[k]) begin
                assert (!gate_low[k])
                    else report_fail($sformatf("phase %0d gate_low on as gate_high fell", k));
                since_fall[k] <= 1;
            end else if (since_fall[k] != 0 && since_fall[k] < dt) begin
                assert (!gate_low[k])
                    else report_fail($sformatf("phase %0d gate_low on inside deadtime", k));
                since_fall[k] <= since_fall[k] + 1;
            end else if (since_fall[k] == dt) begin
                assert (gate_low[k])
                    else report_fail($sformatf("phase %0d gate_low off after deadtime", k));
                since_fall[k] <= 0;
            end
        end
    end

    initial begin
        int errs;
        int d1;
        int d2;
        int lag;
        int exp_lag;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        period_in = '0;
        duty_in = '0;
        phase_shift_in = '0;
        configured = 1'b0;
        started = 1'b0;
        stopped = 1'b0;
        armed = 1'b0;
        for (int k = 0; k < n_ph; k++) begin
            draw(0, period_clocks - dt - 1, shift[k]);
            phase_shift_in[k] = `BUCK_CNT_W'(shift[k]);
        end
        wait_until(c_reset_off, 20, "reset release");

        errs = errors;
        repeat (8) @(posedge clock);
        finish_test("reset state", errs);

        errs = errors;
        configured <= 1'b1;
        pulse_strobe(0);
        wait_state(wait_period, 20, "processor to wait for a period change");
        @(posedge clock);
        period_in <= `BUCK_CNT_W'(period_clocks);
        wait_until(c_done, 400, "done after configuration");
        repeat (10) @(posedge clock);
        assert (done_count == 1)
            else report_fail($sformatf("done pulsed %0d times", done_count));
        finish_test("configuration", errs);

        errs = errors;
        started <= 1'b1;
        pulse_strobe(1);
        wait_until(c_status_on, 20, "modulator_status after start");
        draw(dt + 2, period_clocks - dt - 1, d1);
        duty_in <= `BUCK_CNT_W'(d1);
        pulse_strobe(3);
        wait_state(update_duty, 20, "duty update to begin");
        wait_state(idle, 100, "duty update to finish");
        assert (modulator_status) else report_fail("modulator_status low after start");
        measure_duty(d1);
        finish_test("start and duty", errs);

        errs = errors;
        for (int k = 1; k < n_ph; k++) begin
            lag = ((rise_cycle[k] - rise_cycle[0]) % period_clocks + period_clocks)
                  % period_clocks;
            exp_lag = ((period_clocks - (shift[k] - shift[0])) % period_clocks
                       + period_clocks) % period_clocks;
            assert (lag == exp_lag)
                else report_fail($sformatf("phase %0d lags by %0d clocks, expected %0d",
                                           k, lag, exp_lag));
        end
        finish_test("phase shift", errs);

        errs = errors;
        draw(dt + 2, period_clocks - dt - 1, d2);
        if (d2 == d1) d2 = (d1 == dt + 2) ? d1 + 1 : dt + 2;
        duty_in <= `BUCK_CNT_W'(d2);
        pulse_strobe(3);
        wait_state(update_duty, 20, "second duty update to begin");
        wait_state(idle, 100, "second duty update to finish");
        measure_duty(d2);
        finish_test("duty update", errs);

        errs = errors;
        armed <= 1'b0;
        pulse_strobe(2);
        wait_until(c_status_off, 20, "modulator_status to clear after stop");
        wait_until(c_gates_off, 20, "gates to turn off after stop");
        stopped <= 1'b1;
        repeat (3 * period_clocks) @(posedge clock);
        finish_test("stop", errs);

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/tb_clock_gen.sv */
/*
 * Testbench clock and reset source, 40 unit period, reset low for 4 cycles
 */
module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b0; // Active low
        repeat (4) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

/* source/buck_modulation_top.sv */
/*
 * Buck modulation top. Processor writes the PWM bank, carrier and
 * driver turn the bank contents into per-phase gate signals
 */
`include "buck_params.svh"

module buck_modulation_top (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [`BUCK_CNT_W-1:0] period_in,
    input  logic [`BUCK_CNT_W-1:0] duty_in,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] phase_shift_in,
    output logic done,
    output logic modulator_status,
    output logic [`BUCK_N_PHASES-1:0] gate_high,
    output logic [`BUCK_N_PHASES-1:0] gate_low
);

    logic run;
    logic [`BUCK_CNT_W-1:0] period;
    logic [`BUCK_N_PHASES-1:0] output_enable;
    logic [`BUCK_N_PHASES-1:0] deadtime_enable;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] duty;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] phase_shift;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] deadtime;
    logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] count;

    pwm_write_bus write_bus ();

    buck_pre_modulation_processor processor (
        .clock            (clock),
        .reset            (reset),
        .configure        (configure),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .period_in        (period_in),
        .duty_in          (duty_in),
        .phase_shift_in   (phase_shift_in),
        .done             (done),
        .modulator_status (modulator_status),
        .bus              (write_bus.processor)
    );

    pwm_register_bank bank (
        .clock           (clock),
        .reset           (reset),
        .bus             (write_bus.bank),
        .run             (run),
        .period          (period),
        .output_enable   (output_enable),
        .deadtime_enable (deadtime_enable),
        .duty            (duty),
        .phase_shift     (phase_shift),
        .deadtime        (deadtime)
    );

    pwm_carrier carrier (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .period      (period),
        .phase_shift (phase_shift),
        .count       (count)
    );

    pwm_gate_driver driver (
        .clock           (clock),
        .reset           (reset),
        .count           (count),
        .duty            (duty),
        .deadtime        (deadtime),
        .output_enable   (output_enable),
        .deadtime_enable (deadtime_enable),
        .gate_high       (gate_high),
        .gate_low        (gate_low)
    );

endmodule

/* source/buck_pre_modulation_processor.sv */
/*
 * Buck pre-modulation processor. Turns configure, start, stop and
 * update strobes into register write sequences for the PWM bank
 */
`include "buck_params.svh"

module buck_pre_modulation_processor import buck_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [`BUCK_CNT_W-1:0] period_in,
    input  logic [`BUCK_CNT_W-1:0] duty_in,
    input  logic [`BUCK_N_PHASES-1:0][`BUCK_CNT_W-1:0] phase_shift_in,
    output logic done,
    output logic modulator_status,
    pwm_write_bus.processor bus
);

    localparam int ph_w = $clog2(`BUCK_N_PHASES);
    localparam logic [ph_w-1:0] last_phase = ph_w'(`BUCK_N_PHASES - 1);

    proc_state_e state;
    proc_state_e next_state; // Where write_strobe returns to
    logic [ph_w-1:0] phase_idx;
    logic [2:0] chain_idx;
    logic [`BUCK_CNT_W-1:0] period_d;
    logic [`BUCK_CNT_W-1:0] period_latch;
    logic update_pending;
    logic last_write;
    pwm_reg_e chain_offset;
    logic [31:0] chain_data;
    logic [31:0] phase_base;

    assign phase_base = 32'(`BUCK_CHAIN_STRIDE) * (32'(phase_idx) + 32'd1);

    // Five chain registers per phase, in write order
    always_comb begin
        case (chain_idx)
            3'd0: begin
                chain_offset = reg_deadtime;
                chain_data = 32'(`BUCK_DEADTIME);
            end
            3'd1: begin
                chain_offset = reg_counter_stop;
                chain_data = 32'(period_latch);
            end
            3'd2: begin
                chain_offset = reg_period;
                chain_data = 32'(period_latch);
            end
            3'd3: begin
                chain_offset = reg_output_enable;
                chain_data = 32'd1;
            end
            default: begin
                chain_offset = reg_deadtime_enable;
                chain_data = 32'd1;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            next_state <= idle;
            phase_idx <= '0;
            chain_idx <= '0;
            period_d <= '0;
            period_latch <= '0;
            update_pending <= 1'b0;
            last_write <= 1'b0;
            done <= 1'b0;
            modulator_status <= 1'b0;
            bus.dest <= '0;
            bus.data <= '0;
            bus.valid <= 1'b0;
        end else begin
            period_d <= period_in;
            update_pending <= update_pending | update; // Held while busy
            done <= 1'b0;
            case (state)
                idle: begin
                    if (configure) begin
                        bus.dest.raw <= 32'd0; // Counters off first
                        bus.data <= gc_idle_word;
                        bus.valid <= 1'b1;
                        next_state <= wait_period;
                        state <= write_strobe;
                    end else if (start) begin
                        state <= wait_start;
                    end else if (stop) begin
                        modulator_status <= 1'b0;
                        bus.dest.raw <= 32'd0;
                        bus.data <= gc_idle_word;
                        bus.valid <= 1'b1;
                        next_state <= idle;
                        state <= write_strobe;
                    end else if (update_pending) begin
                        update_pending <= update;
                        phase_idx <= '0;
                        state <= update_duty;
                    end
                end
                wait_period: begin
                    if (period_in != period_d) begin
                        period_latch <= period_in;
                        phase_idx <= '0;
                        chain_idx <= '0;
                        state <= configure_chain;
                    end
                end
                configure_chain: begin
                    if (bus.ready) begin
                        bus.dest.raw <= phase_base + 32'(chain_offset);
                        bus.data <= chain_data;
                        bus.valid <= 1'b1;
                        state <= write_strobe;
                        next_state <= configure_chain;
                        if (chain_idx == 3'd4) begin
                            chain_idx <= '0;
                            if (phase_idx == last_phase) begin
                                phase_idx <= '0;
                                next_state <= configure_shifts;
                            end else begin
                                phase_idx <= phase_idx + 1'b1;
                            end
                        end else begin
                            chain_idx <= chain_idx + 1'b1;
                        end
                    end
                end
                configure_shifts: begin
                    if (bus.ready) begin
                        bus.dest.raw <= phase_base + 32'(reg_phase_shift);
                        bus.data <= 32'(phase_shift_in[phase_idx]);
                        bus.valid <= 1'b1;
                        state <= write_strobe;
                        if (phase_idx == last_phase) begin
                            phase_idx <= '0;
                            last_write <= 1'b1; // done follows this write
                            next_state <= idle;
                        end else begin
                            phase_idx <= phase_idx + 1'b1;
                            next_state <= configure_shifts;
                        end
                    end
                end
                write_strobe: begin
                    bus.valid <= 1'b0;
                    if (!bus.ready) begin // Bank took the write
                        done <= last_write;
                        last_write <= 1'b0;
                        state <= next_state;
                    end
                end
                wait_start: begin
                    if (bus.ready) begin
                        modulator_status <= 1'b1;
                        bus.dest.raw <= 32'd0;
                        bus.data <= gc_on_word;
                        bus.valid <= 1'b1;
                        next_state <= idle;
                        state <= write_strobe;
                    end
                end
                update_duty: begin
                    if (bus.ready) begin
                        bus.dest.raw <= phase_base + 32'(reg_duty);
                        bus.data <= 32'(duty_in);
                        bus.valid <= 1'b1;
                        state <= write_strobe;
                        if (phase_idx == last_phase) begin
                            phase_idx <= '0;
                            next_state <= idle;
                        end else begin
                            phase_idx <= phase_idx + 1'b1;
                            next_state <= update_duty;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule
